/* bench/r5p_bus_sys_tb.sv */
// r5p bus subsystem testbench
// table driven bus transfers checked against a memory and counter model

`timescale 1ns/100ps

module r5p_bus_sys_tb;

  import r5p_bus_pkg::*;

  localparam realtime DRV_DLY   = 0.5;  // inputs move after the rising edge
  localparam int      ACK_LIMIT = 20;   // cycles to wait for ack
  localparam int      NUM_ENT   = 14;

  typedef enum logic [1:0] {
    OP_RD,
    OP_WR,
    OP_VIOL  // write whose address moves while waiting
  } op_t;

  typedef struct packed {
    op_t      op;
    bus_adr_t adr;
    bus_ben_t ben;
    wait_t    w;   // wait states for this entry
    logic     en;  // statistics enable
  } entry_t;

  logic     clk;
  logic     rst;
  logic     req;
  logic     wen;
  bus_adr_t adr;
  bus_ben_t ben;
  bus_dat_t wdt;
  bus_dat_t rdt;
  logic     ack;
  logic     cfg_wen;
  logic     cfg_ren;
  reg_adr_t cfg_adr;
  bus_dat_t cfg_wdt;
  bus_dat_t cfg_rdt;

  entry_t      tbl [NUM_ENT];
  bus_dat_t    mdl_mem [MEM_DEPTH];  // reference memory
  cnt_t        exp_rd;
  cnt_t        exp_wr;
  cnt_t        exp_stall;
  cnt_t        exp_err;
  logic [31:0] lfsr;

  r5p_bus_sys dut (
    .clk (clk), .rst (rst),
    .req (req), .wen (wen), .adr (adr), .ben (ben), .wdt (wdt), .rdt (rdt), .ack (ack),
    .cfg_wen (cfg_wen), .cfg_ren (cfg_ren), .cfg_adr (cfg_adr),
    .cfg_wdt (cfg_wdt), .cfg_rdt (cfg_rdt)
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_dat(input string name, input bus_dat_t exp, input bus_dat_t act);
    if (act !== exp)
      fail_stop($sformatf("** Error at %0t: %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
    if (act !== exp)
      fail_stop($sformatf("** Error at %0t: %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp)
      fail_stop($sformatf("** Error at %0t: %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois form, taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_word(output bus_dat_t d);
    for (int i = 0; i < DAT_W; i++) begin
      d[i] = lfsr[0];  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #(DRV_DLY);
  endtask

  // all helpers start and end at DRV_DLY after a rising edge
  task automatic cfg_write(input reg_adr_t a, input bus_dat_t d);
    cfg_wen = 1'b1;
    cfg_adr = a;
    cfg_wdt = d;
    idle_cycle();  // register takes it here
    cfg_wen = 1'b0;
  endtask

  task automatic cfg_read(input reg_adr_t a, output bus_dat_t d);
    cfg_ren = 1'b1;
    cfg_adr = a;
    idle_cycle();
    cfg_ren = 1'b0;
    @(negedge clk);
    d = cfg_rdt;  // held in the cycle after the strobe
    idle_cycle();
  endtask

  task automatic check_cnt_reg(input reg_adr_t a, input string name, input cnt_t exp);
    bus_dat_t word;
    cfg_read(a, word);
    check_cnt(name, exp, word[CNT_W-1:0]);
    check_dat({name, " upper bits"}, '0, word >> CNT_W);  // zero extended
  endtask

  task automatic check_counters();
    check_cnt_reg(REG_RD_CNT, "rd_cnt", exp_rd);
    check_cnt_reg(REG_WR_CNT, "wr_cnt", exp_wr);
    check_cnt_reg(REG_STALL_CNT, "stall_cnt", exp_stall);
    check_cnt_reg(REG_ERR_CNT, "err_cnt", exp_err);
  endtask

  // one bus transfer with ack latency, read data and model update
  task automatic bus_transfer(input entry_t e, input bus_dat_t d);
    int       cyc;
    logic     acked;
    bus_adr_t cur;  // address at the transfer edge
    req   = 1'b1;
    wen   = (e.op != OP_RD);
    adr   = e.adr;
    ben   = e.ben;
    wdt   = d;
    cur   = e.adr;
    cyc   = 0;
    acked = 1'b0;
    while (!acked) begin
      @(negedge clk);
      if (ack) begin
        acked = 1'b1;
      end else begin
        cyc++;
        if (cyc > ACK_LIMIT)
          fail_stop($sformatf("ack never came for the request at address %h", e.adr));
        idle_cycle();
        if (e.op == OP_VIOL && cyc == 1) begin
          cur = e.adr ^ bus_adr_t'(4);  // next word, pending request moves
          adr = cur;
        end
      end
    end
    check_cycles("ack latency", int'(e.w), cyc);
    idle_cycle();  // transfer edge
    req = 1'b0;
    wen = 1'b0;
    if (e.op == OP_RD) begin
      @(negedge clk);
      check_dat("rdt", mdl_mem[cur[MEM_AW+1:2]], rdt);
    end else begin
      for (int i = 0; i < BEN_W; i++)
        if (e.ben[i]) mdl_mem[cur[MEM_AW+1:2]][8*i +: 8] = d[8*i +: 8];
    end
    if (e.en) begin
      if (e.op == OP_RD) exp_rd = exp_rd + cnt_t'(1);
      else               exp_wr = exp_wr + cnt_t'(1);
      exp_stall = exp_stall + cnt_t'(e.w);  // one per wait cycle
      if (e.op == OP_VIOL) exp_err = exp_err + cnt_t'(1);
    end
    idle_cycle();
  endtask

  task automatic load_table();
    tbl[0]  = '{OP_WR,   16'h0010, 4'hF, 3'd0, 1'b1};
    tbl[1]  = '{OP_WR,   16'h0010, 4'h5, 3'd1, 1'b1};  // merge lanes 0 and 2
    tbl[2]  = '{OP_RD,   16'h0010, 4'hF, 3'd2, 1'b1};
    tbl[3]  = '{OP_WR,   16'h0104, 4'hF, 3'd3, 1'b1};
    tbl[4]  = '{OP_WR,   16'h0104, 4'hC, 3'd0, 1'b1};
    tbl[5]  = '{OP_RD,   16'h0104, 4'hF, 3'd1, 1'b1};
    tbl[6]  = '{OP_VIOL, 16'h0020, 4'hF, 3'd2, 1'b1};  // lands on 0x0024
    tbl[7]  = '{OP_RD,   16'h0024, 4'hF, 3'd0, 1'b1};
    tbl[8]  = '{OP_WR,   16'h03FC, 4'hF, 3'd7, 1'b0};  // counters frozen
    tbl[9]  = '{OP_RD,   16'h0010, 4'hF, 3'd5, 1'b0};
    tbl[10] = '{OP_VIOL, 16'h0040, 4'hF, 3'd3, 1'b0};
    tbl[11] = '{OP_RD,   16'h0044, 4'hF, 3'd4, 1'b1};
    tbl[12] = '{OP_WR,   16'h03FC, 4'h6, 3'd2, 1'b1};
    tbl[13] = '{OP_RD,   16'h03FC, 4'hF, 3'd6, 1'b1};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bus_dat_t word;
    bus_dat_t d;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    wen       = 1'b0;
    adr       = '0;
    ben       = '0;
    wdt       = '0;
    cfg_wen   = 1'b0;
    cfg_ren   = 1'b0;
    cfg_adr   = '0;
    cfg_wdt   = '0;
    lfsr      = 32'd32;  // seed
    exp_rd    = '0;
    exp_wr    = '0;
    exp_stall = '0;
    exp_err   = '0;
    load_table();
    repeat (2) @(posedge clk);
    #(DRV_DLY);
    rst = 1'b0;

    // every register reads zero out of reset, unmapped ones too
    for (int a = 0; a < 8; a++) begin
      cfg_read(reg_adr_t'(a), word);
      check_dat($sformatf("cfg_rdt reg %0d", a), '0, word);
    end

    for (int i = 0; i < NUM_ENT; i++) begin
      cfg_write(REG_WAIT, bus_dat_t'(tbl[i].w));
      cfg_write(REG_CTRL, bus_dat_t'(tbl[i].en));
      draw_word(d);
      bus_transfer(tbl[i], d);
      check_counters();
    end

    // clear bit, pulse reaches the counters one edge later
    cfg_write(REG_CTRL, bus_dat_t'(2));
    idle_cycle();
    exp_rd    = '0;
    exp_wr    = '0;
    exp_stall = '0;
    exp_err   = '0;
    check_counters();
    cfg_read(REG_CTRL, word);
    check_dat("ctrl", '0, word);  // clear bit not stored
    cfg_read(REG_WAIT, word);
    check_dat("wait", bus_dat_t'(tbl[NUM_ENT-1].w), word);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule: r5p_bus_sys_tb

/* r5p_bus_sys.f */
rtl/r5p_bus_pkg.sv
rtl/r5p_bus_mem.sv
rtl/r5p_bus_mon.sv
rtl/r5p_bus_mon_regs.sv
rtl/r5p_bus_sys.sv
bench/r5p_bus_sys_tb.sv

/* rtl/r5p_bus_mem.sv */
// r5p bus data memory slave
// word array with byte lane writes, registered read, programmable wait states

`timescale 1ns/100ps

module r5p_bus_mem (
  // system
  input  logic                  clk,
  input  logic                  rst,
  // system bus
  input  logic                  req,
  input  logic                  wen,
  input  r5p_bus_pkg::bus_adr_t adr,
  input  r5p_bus_pkg::bus_ben_t ben,
  input  r5p_bus_pkg::bus_dat_t wdt,
  output r5p_bus_pkg::bus_dat_t rdt,
  output logic                  ack,
  // wait states from config block
  input  r5p_bus_pkg::wait_t    wait_cfg
);

  import r5p_bus_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  bus_dat_t          mem [MEM_DEPTH];  // data array
  logic [MEM_AW-1:0] idx;              // word index
  mem_state_t        state;
  wait_t             wait_cnt;         // cycles left before ack

  assign idx = adr[MEM_AW+1:2];  // byte address to word

  ////////////////////////////////////////////////////////////////////////////
  // wait state control
  ////////////////////////////////////////////////////////////////////////////

  // ack for zero wait comes straight from req
  always_comb begin
    case (state)
      MEM_IDLE: ack = req && (wait_cfg == '0);
      MEM_WAIT: ack = req && (wait_cnt == '0);
      default:  ack = 1'b0;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= MEM_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        MEM_IDLE: begin
          // wait setting captured at request start
          if (req && (wait_cfg != '0)) begin
            state    <= MEM_WAIT;
            wait_cnt <= wait_cfg - wait_t'(1);
          end
        end
        MEM_WAIT: begin
          if (!req || ack) begin
            state <= MEM_IDLE;  // done, or request withdrawn
          end else begin
            wait_cnt <= wait_cnt - wait_t'(1);
          end
        end
        default: state <= MEM_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req && ack && wen) begin
      for (int i = 0; i < BEN_W; i++) begin
        if (ben[i]) mem[idx][8*i +: 8] <= wdt[8*i +: 8];  // byte lane
      end
    end
    if (req && ack && !wen) rdt <= mem[idx];  // valid next cycle
  end

endmodule: r5p_bus_mem

/* rtl/r5p_bus_mon.sv */
// r5p system bus monitor
// delayed bus copy, request stability check, saturating statistics counters

`timescale 1ns/100ps

module r5p_bus_mon (
  // system
  input  logic                  clk,
  input  logic                  rst,
  // observed system bus
  input  logic                  req,
  input  logic                  wen,
  input  r5p_bus_pkg::bus_adr_t adr,
  input  r5p_bus_pkg::bus_ben_t ben,
  input  r5p_bus_pkg::bus_dat_t wdt,
  input  logic                  ack,
  // control from register block
  input  logic                  stat_en,   // counters run
  input  logic                  stat_clr,  // one cycle clear pulse
  // statistics
  output r5p_bus_pkg::cnt_t     rd_cnt,
  output r5p_bus_pkg::cnt_t     wr_cnt,
  output r5p_bus_pkg::cnt_t     stall_cnt,
  output r5p_bus_pkg::cnt_t     err_cnt
);

  import r5p_bus_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  // request fields delayed by one clock
  logic       wen_r;
  bus_adr_t   adr_r;
  bus_ben_t   ben_r;
  bus_dat_t   wdt_r;

  mon_state_t state;  // pending tracking

  // events of the current cycle
  logic       ev_rd;
  logic       ev_wr;
  logic       ev_stall;
  logic       ev_err;
  logic       fld_diff;  // any request field moved

  // saturating increment
  function automatic cnt_t sat_inc(input cnt_t val);
    return (val == '1) ? val : val + cnt_t'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // delayed bus copy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    wen_r <= wen;
    adr_r <= adr;
    ben_r <= ben;
    wdt_r <= wdt;
  end

  // pending when last cycle had req without ack
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= MON_IDLE;
    end else begin
      state <= (req && !ack) ? MON_PEND : MON_IDLE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol check
  ////////////////////////////////////////////////////////////////////////////

  assign fld_diff = (wen != wen_r) || (adr != adr_r) ||
                    (ben != ben_r) || (wdt != wdt_r);

  // pending request dropped or changed before ack
  assign ev_err   = (state == MON_PEND) && (!req || fld_diff);

  assign ev_rd    = req && ack && !wen;  // read transfer
  assign ev_wr    = req && ack && wen;   // write transfer
  assign ev_stall = req && !ack;         // wait cycle

  ////////////////////////////////////////////////////////////////////////////
  // statistics
  ////////////////////////////////////////////////////////////////////////////

  // clear wins over enable
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      stall_cnt <= '0;
      err_cnt   <= '0;
    end else if (stat_clr) begin
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      stall_cnt <= '0;
      err_cnt   <= '0;
    end else if (stat_en) begin
      if (ev_rd)    rd_cnt    <= sat_inc(rd_cnt);
      if (ev_wr)    wr_cnt    <= sat_inc(wr_cnt);
      if (ev_stall) stall_cnt <= sat_inc(stall_cnt);
      if (ev_err)   err_cnt   <= sat_inc(err_cnt);
    end
  end

  // slave acks only a live request on the observed bus
  assert property (@(posedge clk) disable iff (rst) ack |-> req);

endmodule: r5p_bus_mon

/* rtl/r5p_bus_mon_regs.sv */
// r5p bus monitor register block
// strobe config port, monitor enable/clear, memory wait setting, counter readback

`timescale 1ns/100ps

module r5p_bus_mon_regs (
  // system
  input  logic                  clk,
  input  logic                  rst,
  // config port
  input  logic                  cfg_wen,   // write strobe
  input  logic                  cfg_ren,   // read strobe
  input  r5p_bus_pkg::reg_adr_t cfg_adr,
  input  r5p_bus_pkg::bus_dat_t cfg_wdt,
  output r5p_bus_pkg::bus_dat_t cfg_rdt,   // valid cycle after cfg_ren
  // monitor counters
  input  r5p_bus_pkg::cnt_t     rd_cnt,
  input  r5p_bus_pkg::cnt_t     wr_cnt,
  input  r5p_bus_pkg::cnt_t     stall_cnt,
  input  r5p_bus_pkg::cnt_t     err_cnt,
  // control outputs
  output logic                  stat_en,
  output logic                  stat_clr,
  output r5p_bus_pkg::wait_t    wait_cfg
);

  import r5p_bus_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  logic     wr_ctrl;  // write hits REG_CTRL
  logic     wr_wait;  // write hits REG_WAIT
  bus_dat_t rd_mux;   // read data before register

  assign wr_ctrl = cfg_wen && (cfg_adr == REG_CTRL);
  assign wr_wait = cfg_wen && (cfg_adr == REG_WAIT);

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stat_en  <= 1'b0;
      stat_clr <= 1'b0;
      wait_cfg <= '0;
    end else begin
      if (wr_ctrl) stat_en <= cfg_wdt[0];
      stat_clr <= wr_ctrl && cfg_wdt[1];  // pulse, self clearing
      if (wr_wait) wait_cfg <= cfg_wdt[WAIT_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  // clear bit reads back as zero
  always_comb begin
    case (cfg_adr)
      REG_CTRL:      rd_mux = DAT_W'(stat_en);
      REG_WAIT:      rd_mux = DAT_W'(wait_cfg);
      REG_RD_CNT:    rd_mux = DAT_W'(rd_cnt);
      REG_WR_CNT:    rd_mux = DAT_W'(wr_cnt);
      REG_STALL_CNT: rd_mux = DAT_W'(stall_cnt);
      REG_ERR_CNT:   rd_mux = DAT_W'(err_cnt);
      default:       rd_mux = '0;  // unmapped
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      cfg_rdt <= '0;
    end else if (cfg_ren) begin
      cfg_rdt <= rd_mux;  // held until next read
    end
  end

  // one strobe per cycle on the config port
  assert property (@(posedge clk) disable iff (rst) !(cfg_wen && cfg_ren));

endmodule: r5p_bus_mon_regs

/* rtl/r5p_bus_pkg.sv */
// r5p system bus subsystem package
// shared widths, bus and counter types, register map, state encodings

package r5p_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADR_W  = 16;  // bus address
  localparam int unsigned DAT_W  = 32;  // bus data
  localparam int unsigned BEN_W  = 4;   // byte enables, one per byte lane
  localparam int unsigned MEM_AW = 8;   // word index, adr[9:2]
  localparam int unsigned CNT_W  = 16;  // statistics counters
  localparam int unsigned WAIT_W = 3;   // wait state setting
  localparam int unsigned RAD_W  = 3;   // config register address

  // memory depth in words
  localparam int unsigned MEM_DEPTH = 1 << MEM_AW;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ADR_W-1:0]  bus_adr_t;  // byte address
  typedef logic [DAT_W-1:0]  bus_dat_t;  // read/write data
  typedef logic [BEN_W-1:0]  bus_ben_t;  // byte lane select
  typedef logic [CNT_W-1:0]  cnt_t;      // saturates at all ones
  typedef logic [WAIT_W-1:0] wait_t;     // wait cycles before ack
  typedef logic [RAD_W-1:0]  reg_adr_t;  // config register index

  // register map
  localparam reg_adr_t REG_CTRL      = 3'd0;  // [0] stat enable, [1] clear (not stored)
  localparam reg_adr_t REG_WAIT      = 3'd1;  // memory wait states
  localparam reg_adr_t REG_RD_CNT    = 3'd2;
  localparam reg_adr_t REG_WR_CNT    = 3'd3;
  localparam reg_adr_t REG_STALL_CNT = 3'd4;
  localparam reg_adr_t REG_ERR_CNT   = 3'd5;
  // 6 and 7 unmapped, read zero

  // monitor request tracking
  typedef enum logic {
    MON_IDLE,  // no request outstanding
    MON_PEND   // req seen without ack last cycle
  } mon_state_t;

  // memory wait state machine
  typedef enum logic {
    MEM_IDLE,  // ready, zero-wait requests acked here
    MEM_WAIT   // counting down wait cycles
  } mem_state_t;

endpackage: r5p_bus_pkg

/* rtl/r5p_bus_sys.sv */
// r5p bus subsystem top
// data memory slave, bus monitor and its register block

`timescale 1ns/100ps

module r5p_bus_sys (
  // system
  input  logic                  clk,
  input  logic                  rst,
  // system bus from external master
  input  logic                  req,
  input  logic                  wen,
  input  r5p_bus_pkg::bus_adr_t adr,
  input  r5p_bus_pkg::bus_ben_t ben,
  input  r5p_bus_pkg::bus_dat_t wdt,
  output r5p_bus_pkg::bus_dat_t rdt,
  output logic                  ack,
  // config port
  input  logic                  cfg_wen,
  input  logic                  cfg_ren,
  input  r5p_bus_pkg::reg_adr_t cfg_adr,
  input  r5p_bus_pkg::bus_dat_t cfg_wdt,
  output r5p_bus_pkg::bus_dat_t cfg_rdt
);

  import r5p_bus_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////////////////////

  logic  stat_en;    // regs -> monitor
  logic  stat_clr;
  wait_t wait_cfg;   // regs -> memory
  cnt_t  rd_cnt;     // monitor -> regs
  cnt_t  wr_cnt;
  cnt_t  stall_cnt;
  cnt_t  err_cnt;

  // bus slave
  r5p_bus_mem mem (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .wen      (wen),
    .adr      (adr),
    .ben      (ben),
    .wdt      (wdt),
    .rdt      (rdt),
    .ack      (ack),
    .wait_cfg (wait_cfg)
  );

  // watches the same bus
  r5p_bus_mon mon (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .wen       (wen),
    .adr       (adr),
    .ben       (ben),
    .wdt       (wdt),
    .ack       (ack),
    .stat_en   (stat_en),
    .stat_clr  (stat_clr),
    .rd_cnt    (rd_cnt),
    .wr_cnt    (wr_cnt),
    .stall_cnt (stall_cnt),
    .err_cnt   (err_cnt)
  );

  r5p_bus_mon_regs regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_wen   (cfg_wen),
    .cfg_ren   (cfg_ren),
    .cfg_adr   (cfg_adr),
    .cfg_wdt   (cfg_wdt),
    .cfg_rdt   (cfg_rdt),
    .rd_cnt    (rd_cnt),
    .wr_cnt    (wr_cnt),
    .stall_cnt (stall_cnt),
    .err_cnt   (err_cnt),
    .stat_en   (stat_en),
    .stat_clr  (stat_clr),
    .wait_cfg  (wait_cfg)
  );

endmodule: r5p_bus_sys

/* run_sim.sh */
#!/bin/sh
# build and run the r5p bus subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f r5p_bus_sys.f --top-module r5p_bus_sys_tb \
  -Mdir obj_dir -o r5p_bus_sys_sim > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }

./obj_dir/r5p_bus_sys_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" ||
  { echo "simulation failed, see sim.log"; exit 1; }
